/* Makefile */
TOP := tb_freelist

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f freelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "test passed" > /dev/null

clean:
	rm -rf obj_dir

/* core_params_pkg.sv */
package core_params_pkg;

    // rename lanes that can ask for a destination register each cycle
    localparam int RENAME_WIDTH = 4;

    // retire lanes that can free or commit a register each cycle
    localparam int COMMIT_WIDTH = 4;

    // integer physical register file size
    localparam int IPHYREG_NUM = 64;

    // x0 maps to physical register 0 for good and never enters the list
    localparam int FL_DEPTH = IPHYREG_NUM - 1;

endpackage

/* fl_queue_if.sv */
`timescale 1ns/1ps

interface fl_queue_if
    import core_params_pkg::*, freelist_pkg::*;
();

    // freed registers, already packed into the low lanes
    cm_mask_t  enq_mask;
    pr_idx_t   enq_data [COMMIT_WIDTH];

    // number of entries taken at the speculative head
    lane_cnt_t deq_num;
    pr_idx_t   deq_data [RENAME_WIDTH];

    // entries between the speculative head and the tail
    fl_cnt_t   avail;

    logic      resteer;
    lane_cnt_t commit_num;

    modport ctrl (
        output enq_mask, enq_data, deq_num, resteer, commit_num,
        input  deq_data, avail
    );

    modport queue (
        input  enq_mask, enq_data, deq_num, resteer, commit_num,
        output deq_data, avail
    );

endinterface

/* freelist.f */
core_params_pkg.sv
freelist_pkg.sv
fl_queue_if.sv
lane_compact.sv
lane_scatter.sv
spec_fifo.sv
freelist.sv
freelist_chk.sv
tb_clkgen.sv
tb_freelist.sv

/* freelist.sv */
`timescale 1ns/1ps

module freelist
    import core_params_pkg::*, freelist_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,

    // rename side, all lanes granted together or none
    input  rn_mask_t i_alloc_req,
    output logic     o_can_alloc,
    output pr_idx_t  o_alloc_pr [RENAME_WIDTH],

    // registers freed at retire, lanes may be sparse
    input  cm_mask_t i_dealloc_req,
    input  pr_idx_t  i_dealloc_pr [COMMIT_WIDTH],

    // from commit
    input  logic     i_resteer_vld,
    input  cm_mask_t i_commit_vld
);

    // this module plays the ctrl side of the queue link
    fl_queue_if q_if ();

    lane_cnt_t req_num;
    lane_cnt_t commit_num;
    rn_mask_t  grant_mask;

    always_comb begin
        req_num = '0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            req_num = req_num + lane_cnt_t'(i_alloc_req[k]);
        end
    end

    always_comb begin
        commit_num = '0;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            commit_num = commit_num + lane_cnt_t'(i_commit_vld[k]);
        end
    end

    // grant only if every requested lane can be served
    assign o_can_alloc = fl_cnt_t'(req_num) <= q_if.avail;

    // nothing is taken on a denied request or in a resteer cycle
    assign q_if.deq_num    = (o_can_alloc && !i_resteer_vld) ? req_num : '0;
    assign q_if.resteer    = i_resteer_vld;
    assign q_if.commit_num = commit_num;

    // a denied request shows zeros instead of entries past avail
    assign grant_mask = o_can_alloc ? i_alloc_req : '0;

    // freed lanes packed low before the tail write: 0101 -> 0011
    lane_compact u_compact (
        .i_vld  ( i_dealloc_req  ),
        .i_data ( i_dealloc_pr   ),
        .o_vld  ( q_if.enq_mask  ),
        .o_data ( q_if.enq_data  )
    );

    spec_fifo u_fifo (
        .i_clk   ( i_clk          ),
        .i_rst_n ( i_rst_n        ),
        .q       ( q_if.queue     )
    );

    // head entries spread back onto the requesting lanes
    lane_scatter u_scatter (
        .i_vld  ( grant_mask     ),
        .i_data ( q_if.deq_data  ),
        .o_data ( o_alloc_pr     )
    );

endmodule

/* freelist_cases.txt */
# name alloc dealloc dpr0 dpr1 dpr2 dpr3 commit resteer exp_can exp_pr0 exp_pr1 exp_pr2 exp_pr3
# every value in hex, one clock cycle per line
reset_grant0  f 0 00 00 00 00 0 0 1 01 02 03 04
reset_grant1  f 0 00 00 00 00 0 0 1 05 06 07 08
sparse_req    9 0 00 00 00 00 0 0 1 09 00 00 0a
commit_four   0 0 00 00 00 00 f 0 1 00 00 00 00
commit_two    0 0 00 00 00 00 5 0 1 00 00 00 00
resteer       f 0 00 00 00 00 1 1 1 0b 0c 0d 0e
after_resteer f 0 00 00 00 00 0 0 1 08 09 0a 0b
free_sparse   f 5 02 2a 05 2b f 0 1 0c 0d 0e 0f
drain_00      f 0 00 00 00 00 f 0 1 10 11 12 13
drain_01      f 0 00 00 00 00 f 0 1 14 15 16 17
drain_02      f 0 00 00 00 00 f 0 1 18 19 1a 1b
drain_03      f 0 00 00 00 00 f 0 1 1c 1d 1e 1f
drain_04      f 0 00 00 00 00 f 0 1 20 21 22 23
drain_05      f 0 00 00 00 00 f 0 1 24 25 26 27
drain_06      f 0 00 00 00 00 f 0 1 28 29 2a 2b
drain_07      f 0 00 00 00 00 f 0 1 2c 2d 2e 2f
drain_08      f 0 00 00 00 00 f 0 1 30 31 32 33
drain_09      f 0 00 00 00 00 f 0 1 34 35 36 37
drain_10      f 8 00 00 00 07 f 0 1 38 39 3a 3b
drain_11      f 0 00 00 00 00 f 0 1 3c 3d 3e 3f
deny_big      f 0 00 00 00 00 f 0 0 00 00 00 00
deny_again    f 0 00 00 00 00 0 0 0 00 00 00 00
reuse_freed   7 0 00 00 00 00 0 0 1 02 05 07 00
empty_deny    1 0 00 00 00 00 0 0 0 00 00 00 00
free_mid      0 6 00 09 0a 00 7 0 1 00 00 00 00
reuse_mid     3 0 00 00 00 00 0 0 1 09 0a 00 00

/* freelist_chk.sv */
`timescale 1ns/1ps

module freelist_chk
    import core_params_pkg::*, freelist_pkg::*;
(
    input logic    i_clk,
    input logic    i_rst_n,
    input fl_ptr_t i_tail,
    input fl_ptr_t i_sp_head,
    input fl_ptr_t i_cm_head,
    input fl_cnt_t i_avail,
    input logic    i_resteer
);

    // pointer distances, wrap bit included
    fl_ptr_t fill_cm;
    fl_ptr_t spec_lead;

    assign fill_cm   = i_tail - i_cm_head;
    assign spec_lead = i_sp_head - i_cm_head;

    avail_limit: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_avail <= fl_cnt_t'(FL_DEPTH)
    ) else $error("free list reports more than %0d free entries", FL_DEPTH);

    // freed registers can never outnumber those not yet committed
    tail_limit: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        fill_cm <= fl_ptr_t'(FL_DEPTH)
    ) else $error("tail ran more than %0d entries past the committed head", FL_DEPTH);

    spec_ahead: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_resteer |-> spec_lead <= fl_ptr_t'(FL_DEPTH)
    ) else $error("speculative head fell behind the committed head");

endmodule

bind spec_fifo freelist_chk u_chk (
    .i_clk     ( i_clk     ),
    .i_rst_n   ( i_rst_n   ),
    .i_tail    ( tail_ptr  ),
    .i_sp_head ( sp_head   ),
    .i_cm_head ( cm_head   ),
    .i_avail   ( q.avail   ),
    .i_resteer ( q.resteer )
);

/* freelist_pkg.sv */
package freelist_pkg;

    import core_params_pkg::*;

    localparam int PR_IDX_W   = $clog2(IPHYREG_NUM);
    localparam int LANE_IDX_W = $clog2(RENAME_WIDTH);
    localparam int LANE_CNT_W = $clog2(RENAME_WIDTH + 1);

    // extra wrap bit separates a full queue from an empty one
    localparam int FL_PTR_W = PR_IDX_W + 1;

    typedef logic [PR_IDX_W-1:0]     pr_idx_t;
    typedef logic [RENAME_WIDTH-1:0] rn_mask_t;
    typedef logic [COMMIT_WIDTH-1:0] cm_mask_t;

    // lane position inside a group, and a count of lanes from 0 to 4
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;
    typedef logic [LANE_CNT_W-1:0] lane_cnt_t;

    typedef logic [FL_PTR_W-1:0] fl_ptr_t;

    // same width as a pointer so occupancy is a plain pointer difference
    typedef logic [FL_PTR_W-1:0] fl_cnt_t;

endpackage

/* lane_compact.sv */
`timescale 1ns/1ps

module lane_compact
    import core_params_pkg::*, freelist_pkg::*;
(
    input  cm_mask_t i_vld,
    input  pr_idx_t  i_data [COMMIT_WIDTH],
    output cm_mask_t o_vld,
    output pr_idx_t  o_data [COMMIT_WIDTH]
);

    // next free output slot while walking the lanes from the bottom
    lane_idx_t pos;

    // each valid lane lands on the slot equal to the number of valid
    // lanes below it, e.g. 1010 -> 0011, order among them is kept
    always_comb begin
        pos    = '0;
        o_vld  = '0;
        o_data = '{default: '0};
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            if (i_vld[k]) begin
                o_data[pos] = i_data[k];
                o_vld[pos]  = 1'b1;
                pos         = pos + lane_idx_t'(1);
            end
        end
    end

endmodule

/* lane_scatter.sv */
`timescale 1ns/1ps

module lane_scatter
    import core_params_pkg::*, freelist_pkg::*;
(
    input  rn_mask_t i_vld,
    input  pr_idx_t  i_data [RENAME_WIDTH],
    output pr_idx_t  o_data [RENAME_WIDTH]
);

    // index of the next packed entry to hand out
    lane_idx_t src;

    // requested lane k takes packed entry j, j = requested lanes below k
    // xxba with request 1001 gives b00a
    always_comb begin
        src    = '0;
        o_data = '{default: '0};
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            if (i_vld[k]) begin
                o_data[k] = i_data[src];
                src       = src + lane_idx_t'(1);
            end
        end
    end

endmodule

/* spec_fifo.sv */
`timescale 1ns/1ps

module spec_fifo
    import core_params_pkg::*, freelist_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    fl_queue_if.queue    q
);

    // 64 slots, at most 63 of them hold a free register
    pr_idx_t   mem [IPHYREG_NUM];

    fl_ptr_t   tail_ptr;
    fl_ptr_t   sp_head;
    fl_ptr_t   cm_head;

    fl_ptr_t   cm_head_nxt;
    fl_ptr_t   sp_head_nxt;
    lane_cnt_t enq_num;

    fl_ptr_t   wr_ptr [COMMIT_WIDTH];
    fl_ptr_t   rd_ptr [RENAME_WIDTH];

    // enq_mask is a run of low ones, so its popcount is the write count
    always_comb begin
        enq_num = '0;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            enq_num = enq_num + lane_cnt_t'(q.enq_mask[k]);
        end
    end

    always_comb begin
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            wr_ptr[k] = tail_ptr + fl_ptr_t'(k);
        end
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            rd_ptr[k] = sp_head + fl_ptr_t'(k);
        end
    end

    // a resteer drops every uncommitted grant, this cycle's commits included
    assign cm_head_nxt = cm_head + fl_ptr_t'(q.commit_num);
    assign sp_head_nxt = q.resteer ? cm_head_nxt : sp_head + fl_ptr_t'(q.deq_num);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            tail_ptr <= fl_ptr_t'(FL_DEPTH);
            sp_head  <= '0;
            cm_head  <= '0;
        end else begin
            tail_ptr <= tail_ptr + fl_ptr_t'(enq_num);
            sp_head  <= sp_head_nxt;
            cm_head  <= cm_head_nxt;
        end
    end

    // list starts as 1..63 in slots 0..62
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                mem[i] <= pr_idx_t'(i + 1);
            end
        end else begin
            for (int k = 0; k < COMMIT_WIDTH; k++) begin
                if (q.enq_mask[k]) begin
                    mem[wr_ptr[k][PR_IDX_W-1:0]] <= q.enq_data[k];
                end
            end
        end
    end

    // next four entries after the speculative head, valid up to avail
    always_comb begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            q.deq_data[k] = mem[rd_ptr[k][PR_IDX_W-1:0]];
        end
    end

    assign q.avail = fl_cnt_t'(tail_ptr - sp_head);

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk
);

    // 40 ns period, first rising edge at 20 ns
    localparam int HALF_PERIOD_NS = 20;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS * 1ns);
            o_clk = ~o_clk;
        end
    end

endmodule

/* tb_freelist.sv */
`timescale 1ns/1ps

module tb_freelist
    import core_params_pkg::*, freelist_pkg::*;
();

    localparam int    RESET_CYCLES  = 16;
    localparam int    RESET_TIMEOUT = 100;
    localparam int    MAX_LINES     = 1000;
    localparam string CASES_FILE    = "freelist_cases.txt";

    logic     clk;
    logic     rst_n;
    rn_mask_t alloc_req;
    logic     can_alloc;
    pr_idx_t  alloc_pr [RENAME_WIDTH];
    cm_mask_t dealloc_req;
    pr_idx_t  dealloc_pr [COMMIT_WIDTH];
    logic     resteer_vld;
    cm_mask_t commit_vld;

    tb_clkgen u_clkgen (
        .o_clk ( clk )
    );

    freelist u_dut (
        .i_clk         ( clk         ),
        .i_rst_n       ( rst_n       ),
        .i_alloc_req   ( alloc_req   ),
        .o_can_alloc   ( can_alloc   ),
        .o_alloc_pr    ( alloc_pr    ),
        .i_dealloc_req ( dealloc_req ),
        .i_dealloc_pr  ( dealloc_pr  ),
        .i_resteer_vld ( resteer_vld ),
        .i_commit_vld  ( commit_vld  )
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(
        input string       case_name,
        input string       what,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        string msg;
        if (actual !== expected) begin
            msg = $sformatf("error: case %s, %s expected %0h, actual %0h",
                            case_name, what, expected, actual);
            fail_run(msg);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          cycles;
        int          num_lines;
        int          num_cases;
        string       line;
        string       case_name;
        logic [31:0] f_alloc;
        logic [31:0] f_dealloc;
        logic [31:0] f_dpr [COMMIT_WIDTH];
        logic [31:0] f_commit;
        logic [31:0] f_resteer;
        logic [31:0] f_can;
        logic [31:0] f_pr [RENAME_WIDTH];

        void'($urandom(69));

        rst_n       = 1'b0;
        alloc_req   = '0;
        dealloc_req = '0;
        dealloc_pr  = '{default: '0};
        resteer_vld = 1'b0;
        commit_vld  = '0;

        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the cases file freelist_cases.txt");
        end

        // reset held over 16 rising edges
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;

        // with no request the grant output is known only once the pointers are set
        cycles = 0;
        while (can_alloc !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                fail_run("the free list did not come out of reset in time");
            end
        end

        num_lines = 0;
        num_cases = 0;
        while (!$feof(fd)) begin
            num_lines++;
            if (num_lines > MAX_LINES) begin
                fail_run("the cases file has more lines than expected");
            end
            line = "";
            n    = $fgets(line, fd);
            // blank lines and comment lines carry no cycle
            if (n < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        case_name, f_alloc, f_dealloc,
                        f_dpr[0], f_dpr[1], f_dpr[2], f_dpr[3],
                        f_commit, f_resteer, f_can,
                        f_pr[0], f_pr[1], f_pr[2], f_pr[3]);
            if (n != 14) begin
                fail_run($sformatf("cannot parse line %0d of the cases file", num_lines));
            end

            // one line is one clock cycle
            @(posedge clk);
            alloc_req   <= rn_mask_t'(f_alloc);
            dealloc_req <= cm_mask_t'(f_dealloc);
            for (int k = 0; k < COMMIT_WIDTH; k++) begin
                dealloc_pr[k] <= pr_idx_t'(f_dpr[k]);
            end
            commit_vld  <= cm_mask_t'(f_commit);
            resteer_vld <= f_resteer[0];

            // grant outputs are combinational, sampled mid cycle
            @(negedge clk);
            check_value(case_name, "o_can_alloc", f_can, 32'(can_alloc));
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                check_value(case_name, $sformatf("o_alloc_pr[%0d]", k),
                            f_pr[k], 32'(alloc_pr[k]));
            end
            num_cases++;
        end
        $fclose(fd);

        if (num_cases == 0) begin
            fail_run("no cases were read from freelist_cases.txt");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
